/* hdl/lsu_pkg.sv */
// load/store unit shared definitions
package lsu_pkg;

    localparam int XLEN          = 32;
    localparam int WORD_BYTES    = 4;
    localparam int ALIGN_BITS    = 2;
    localparam int WB_ADDR_WIDTH = 30;
    localparam int OFFSET_WIDTH  = 12;
    localparam int REG_BITS      = 5;
    localparam int UUID_WIDTH    = 8;

    // access size codes
    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        SB  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        SH  = 3'b110,
        SW  = 3'b111
    } lsu_op_t;

    typedef struct packed {
        logic [UUID_WIDTH-1:0] uuid;
        logic [REG_BITS-1:0]   rd;
        logic [XLEN-1:0]       data;
    } load_result_t;

    typedef struct packed {
        logic [UUID_WIDTH-1:0] uuid;
    } store_done_t;

    function automatic logic op_is_store(lsu_op_t op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic logic [1:0] op_size(lsu_op_t op);
        case (op)
            LB, LBU, SB: return SZ_BYTE;
            LH, LHU, SH: return SZ_HALF;
            default:     return SZ_WORD;
        endcase
    endfunction

endpackage

/* hdl/lsu_request_format.sv */
// request address and data formatting
module lsu_request_format (
    input  lsu_pkg::lsu_op_t                       op,
    input  logic [lsu_pkg::XLEN-1:0]               base,
    input  logic [lsu_pkg::OFFSET_WIDTH-1:0]       offset,
    input  logic [lsu_pkg::XLEN-1:0]               store_data,
    output logic [lsu_pkg::WB_ADDR_WIDTH-1:0]      word_addr,
    output logic [lsu_pkg::ALIGN_BITS-1:0]         align,
    output logic [lsu_pkg::WORD_BYTES-1:0]         byte_en,
    output logic [lsu_pkg::XLEN-1:0]               wdata
);
    import lsu_pkg::*;

    logic [XLEN-1:0] eff_addr;
    logic [XLEN-1:0] offset_ext;

    assign offset_ext = {{(XLEN-OFFSET_WIDTH){offset[OFFSET_WIDTH-1]}}, offset};
    assign eff_addr   = base + offset_ext;

    assign word_addr = eff_addr[XLEN-1:ALIGN_BITS];
    assign align     = eff_addr[ALIGN_BITS-1:0];

    always_comb begin
        case (op_size(op))
            SZ_BYTE: begin
                byte_en = WORD_BYTES'(1) << align;
            end
            SZ_HALF: begin
                // pair select from upper align bit
                byte_en = WORD_BYTES'(3) << {align[1], 1'b0};
            end
            default: begin
                byte_en = '1;
            end
        endcase
    end

    // move the low lanes up to the addressed byte
    assign wdata = store_data << {align, 3'b000};

endmodule

/* hdl/lsu_wb_master.sv */
// wishbone classic master
module lsu_wb_master (
    input  logic                                   clk,
    input  logic                                   reset,

    input  logic                                   req_valid,
    output logic                                   req_ready,
    input  lsu_pkg::lsu_op_t                       op,
    input  logic [lsu_pkg::WB_ADDR_WIDTH-1:0]      word_addr,
    input  logic [lsu_pkg::ALIGN_BITS-1:0]         align,
    input  logic [lsu_pkg::WORD_BYTES-1:0]         byte_en,
    input  logic [lsu_pkg::XLEN-1:0]               wdata,
    input  logic [lsu_pkg::REG_BITS-1:0]           rd,
    input  logic [lsu_pkg::UUID_WIDTH-1:0]         uuid,

    output logic                                   wb_cyc,
    output logic                                   wb_stb,
    output logic                                   wb_we,
    output logic [lsu_pkg::WB_ADDR_WIDTH-1:0]      wb_adr,
    output logic [lsu_pkg::WORD_BYTES-1:0]         wb_sel,
    output logic [lsu_pkg::XLEN-1:0]               wb_dat_w,
    input  logic                                   wb_ack,
    input  logic [lsu_pkg::XLEN-1:0]               wb_dat_r,

    output logic                                   load_valid,
    input  logic                                   load_ready,
    output logic [lsu_pkg::XLEN-1:0]               load_raw,
    output lsu_pkg::lsu_op_t                       load_op,
    output logic [lsu_pkg::ALIGN_BITS-1:0]         load_align,
    output logic [lsu_pkg::REG_BITS-1:0]           load_rd,
    output logic [lsu_pkg::UUID_WIDTH-1:0]         load_uuid,

    output logic                                   store_valid,
    input  logic                                   store_ready,
    output logic [lsu_pkg::UUID_WIDTH-1:0]         store_uuid
);
    import lsu_pkg::*;

    logic                       busy;
    logic                       cyc_q;
    lsu_op_t                    op_q;
    logic [ALIGN_BITS-1:0]      align_q;
    logic [REG_BITS-1:0]        rd_q;
    logic [UUID_WIDTH-1:0]      uuid_q;
    logic [WB_ADDR_WIDTH-1:0]   adr_q;
    logic [WORD_BYTES-1:0]      sel_q;
    logic [XLEN-1:0]            dat_q;
    logic                       req_fire;
    logic                       held_is_store;
    logic                       new_dest_ready;
    logic                       held_dest_ready;
    logic                       ack_fire;

    assign req_ready = ~busy;
    assign req_fire  = req_valid & req_ready;

    // destination buffer space is checked before stb goes up
    assign new_dest_ready  = op_is_store(op) ? store_ready : load_ready;
    assign held_is_store   = op_is_store(op_q);
    assign held_dest_ready = held_is_store ? store_ready : load_ready;
    assign ack_fire        = cyc_q & wb_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            cyc_q <= 1'b0;
        end else if (req_fire) begin
            busy  <= 1'b1;
            cyc_q <= new_dest_ready;
        end else if (ack_fire) begin
            busy  <= 1'b0;
            cyc_q <= 1'b0;
        end else if (busy && !cyc_q && held_dest_ready) begin
            cyc_q <= 1'b1;
        end
    end

    // request and tag
    always_ff @(posedge clk) begin
        if (req_fire) begin
            op_q    <= op;
            align_q <= align;
            rd_q    <= rd;
            uuid_q  <= uuid;
            adr_q   <= word_addr;
            sel_q   <= byte_en;
            dat_q   <= wdata;
        end
    end

    assign wb_cyc   = cyc_q;
    assign wb_stb   = cyc_q;
    assign wb_we    = held_is_store;
    assign wb_adr   = adr_q;
    assign wb_sel   = sel_q;
    assign wb_dat_w = dat_q;

    assign load_valid = ack_fire & ~held_is_store;
    assign load_raw   = wb_dat_r;
    assign load_op    = op_q;
    assign load_align = align_q;
    assign load_rd    = rd_q;
    assign load_uuid  = uuid_q;

    assign store_valid = ack_fire & held_is_store;
    assign store_uuid  = uuid_q;

endmodule

/* hdl/lsu_load_align.sv */
// load data extraction and extension
module lsu_load_align (
    input  logic [lsu_pkg::XLEN-1:0]           raw,
    input  lsu_pkg::lsu_op_t                   op,
    input  logic [lsu_pkg::ALIGN_BITS-1:0]     align,
    output logic [lsu_pkg::XLEN-1:0]           data
);
    import lsu_pkg::*;

    logic [15:0] half_sel;
    logic [7:0]  byte_sel;

    // upper align bit picks the half, lower bit the byte in it
    assign half_sel = align[1] ? raw[31:16] : raw[15:0];
    assign byte_sel = align[0] ? half_sel[15:8] : half_sel[7:0];

    always_comb begin
        case (op)
            LB: begin
                data = {{(XLEN-8){byte_sel[7]}}, byte_sel};
            end
            LH: begin
                data = {{(XLEN-16){half_sel[15]}}, half_sel};
            end
            LBU: begin
                data = {{(XLEN-8){1'b0}}, byte_sel};
            end
            LHU: begin
                data = {{(XLEN-16){1'b0}}, half_sel};
            end
            default: begin
                data = raw;
            end
        endcase
    end

endmodule

/* hdl/lsu_elastic_buffer.sv */
// two-entry elastic buffer
module lsu_elastic_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     out_valid_q;
    logic     skid_valid_q;
    payload_t out_data_q;
    payload_t skid_data_q;
    logic     out_free;
    logic     in_fire;

    // output slot can take a new entry this cycle
    assign out_free = ~out_valid_q | out_ready;
    assign in_ready = ~skid_valid_q;
    assign in_fire  = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_free) begin
            out_valid_q  <= skid_valid_q | in_valid;
            skid_valid_q <= 1'b0;
        end else if (in_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data_q <= skid_valid_q ? skid_data_q : in_data;
        end else if (in_fire) begin
            skid_data_q <= in_data;
        end
    end

    assign out_valid = out_valid_q;
    assign out_data  = out_data_q;

endmodule

/* hdl/lsu_result_arb.sv */
// result stream merge, loads first
module lsu_result_arb (
    input  logic                               load_valid,
    output logic                               load_ready,
    input  lsu_pkg::load_result_t              load_data,

    input  logic                               store_valid,
    output logic                               store_ready,
    input  lsu_pkg::store_done_t               store_data,

    output logic                               result_valid,
    input  logic                               result_ready,
    output logic [lsu_pkg::UUID_WIDTH-1:0]     result_uuid,
    output logic [lsu_pkg::REG_BITS-1:0]       result_rd,
    output logic                               result_wb,
    output logic [lsu_pkg::XLEN-1:0]           result_data
);

    logic load_grant;

    assign load_grant = load_valid;

    assign result_valid = load_valid | store_valid;
    assign load_ready   = result_ready;
    // store waits while a load is pending
    assign store_ready  = result_ready & ~load_grant;

    assign result_wb   = load_grant;
    assign result_uuid = load_grant ? load_data.uuid : store_data.uuid;
    assign result_rd   = load_grant ? load_data.rd : '0;
    assign result_data = load_grant ? load_data.data : '0;

endmodule

/* hdl/lsu_top.sv */
// load/store unit top level
module lsu_top (
    input  logic                                   clk,
    input  logic                                   reset,

    input  logic                                   req_valid,
    output logic                                   req_ready,
    input  lsu_pkg::lsu_op_t                       req_op,
    input  logic [lsu_pkg::XLEN-1:0]               req_base,
    input  logic [lsu_pkg::OFFSET_WIDTH-1:0]       req_offset,
    input  logic [lsu_pkg::XLEN-1:0]               req_store_data,
    input  logic [lsu_pkg::REG_BITS-1:0]           req_rd,
    input  logic [lsu_pkg::UUID_WIDTH-1:0]         req_uuid,

    output logic                                   wb_cyc,
    output logic                                   wb_stb,
    output logic                                   wb_we,
    output logic [lsu_pkg::WB_ADDR_WIDTH-1:0]      wb_adr,
    output logic [lsu_pkg::WORD_BYTES-1:0]         wb_sel,
    output logic [lsu_pkg::XLEN-1:0]               wb_dat_w,
    input  logic                                   wb_ack,
    input  logic [lsu_pkg::XLEN-1:0]               wb_dat_r,

    output logic                                   result_valid,
    input  logic                                   result_ready,
    output logic [lsu_pkg::UUID_WIDTH-1:0]         result_uuid,
    output logic [lsu_pkg::REG_BITS-1:0]           result_rd,
    output logic                                   result_wb,
    output logic [lsu_pkg::XLEN-1:0]               result_data
);
    import lsu_pkg::*;

    logic [WB_ADDR_WIDTH-1:0]   word_addr;
    logic [ALIGN_BITS-1:0]      align;
    logic [WORD_BYTES-1:0]      byte_en;
    logic [XLEN-1:0]            wdata;

    logic                       load_valid;
    logic                       load_ready;
    logic [XLEN-1:0]            load_raw;
    lsu_op_t                    load_op;
    logic [ALIGN_BITS-1:0]      load_align;
    logic [REG_BITS-1:0]        load_rd;
    logic [UUID_WIDTH-1:0]      load_uuid;
    logic [XLEN-1:0]            load_data;

    logic                       store_valid;
    logic                       store_ready;
    logic [UUID_WIDTH-1:0]      store_uuid;

    logic                       lbuf_valid;
    logic                       lbuf_ready;
    load_result_t               lbuf_data;
    logic                       sbuf_valid;
    logic                       sbuf_ready;
    store_done_t                sbuf_data;

    lsu_request_format format_i (
        .op         (req_op),
        .base       (req_base),
        .offset     (req_offset),
        .store_data (req_store_data),
        .word_addr  (word_addr),
        .align      (align),
        .byte_en    (byte_en),
        .wdata      (wdata)
    );

    lsu_wb_master master_i (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .op          (req_op),
        .word_addr   (word_addr),
        .align       (align),
        .byte_en     (byte_en),
        .wdata       (wdata),
        .rd          (req_rd),
        .uuid        (req_uuid),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_sel      (wb_sel),
        .wb_dat_w    (wb_dat_w),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_raw    (load_raw),
        .load_op     (load_op),
        .load_align  (load_align),
        .load_rd     (load_rd),
        .load_uuid   (load_uuid),
        .store_valid (store_valid),
        .store_ready (store_ready),
        .store_uuid  (store_uuid)
    );

    lsu_load_align align_i (
        .raw   (load_raw),
        .op    (load_op),
        .align (load_align),
        .data  (load_data)
    );

    lsu_elastic_buffer #(
        .payload_t (load_result_t)
    ) load_buf_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (load_valid),
        .in_ready  (load_ready),
        .in_data   ({load_uuid, load_rd, load_data}),
        .out_valid (lbuf_valid),
        .out_ready (lbuf_ready),
        .out_data  (lbuf_data)
    );

    lsu_elastic_buffer #(
        .payload_t (store_done_t)
    ) store_buf_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (store_valid),
        .in_ready  (store_ready),
        .in_data   (store_uuid),
        .out_valid (sbuf_valid),
        .out_ready (sbuf_ready),
        .out_data  (sbuf_data)
    );

    lsu_result_arb arb_i (
        .load_valid   (lbuf_valid),
        .load_ready   (lbuf_ready),
        .load_data    (lbuf_data),
        .store_valid  (sbuf_valid),
        .store_ready  (sbuf_ready),
        .store_data   (sbuf_data),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_uuid  (result_uuid),
        .result_rd    (result_rd),
        .result_wb    (result_wb),
        .result_data  (result_data)
    );

endmodule

/* verif/tb_wb_memory.sv */
// wishbone slave memory model
module tb_wb_memory (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [29:0] wb_adr,
    input  logic [3:0]  wb_sel,
    input  logic [31:0] wb_dat_w,
    output logic        wb_ack,
    output logic [31:0] wb_dat_r
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          DEPTH = 256;
    localparam logic [31:0] SEED  = 32'h4949;

    logic [31:0] mem [DEPTH];
    logic [31:0] rng;
    logic [1:0]  wait_left;
    logic        active;
    logic [7:0]  idx;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word index wraps so upper address bits alias
    assign idx = wb_adr[7:0];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'h9e37_79b9 * 32'(i + 1);
        end
    end

    // one setup cycle then 0 to 3 random wait states
    always @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
            active    <= 1'b0;
            wait_left <= '0;
            rng       <= SEED;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
            active <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!active) begin
                active    <= 1'b1;
                wait_left <= rng[1:0];
                rng       <= xorshift(rng);
            end else if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[idx];
                if (wb_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel[b]) begin
                            mem[idx][b*8 +: 8] <= wb_dat_w[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

/* verif/tb_lsu.sv */
// load/store unit testbench
module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_INSTR      = 40;
    localparam int TIMEOUT_CYCLES = 40 * NUM_INSTR + RESET_CYCLES;

    logic        clk;
    logic        reset;
    logic        req_valid;
    logic        req_ready;
    lsu_op_t     req_op;
    logic [31:0] req_base;
    logic [11:0] req_offset;
    logic [31:0] req_store_data;
    logic [4:0]  req_rd;
    logic [7:0]  req_uuid;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [29:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_w;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    logic        result_valid;
    logic        result_ready;
    logic [7:0]  result_uuid;
    logic [4:0]  result_rd;
    logic        result_wb;
    logic [31:0] result_data;

    // reference memory indexed like the 256-word model
    logic [31:0] ref_mem [256];
    logic [44:0] exp_ld [$];
    logic [7:0]  exp_st [$];
    logic [66:0] exp_bus [$];
    logic [7:0]  next_uuid;
    int          issued;
    int          errors;
    int          checks;
    int          tests;
    int          test_base;
    int          cycles;

    lsu_top dut_i (.*);
    tb_wb_memory mem_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // bus cycles are checked in issue order at the acknowledge
    always @(posedge clk) begin
        logic [66:0] bus;
        logic [31:0] mask;
        if (wb_cyc && wb_ack) begin
            if (exp_bus.size() == 0) begin
                $display("bus cycle at %0t with no instruction outstanding", $time);
                errors++;
            end else begin
                bus = exp_bus.pop_front();
                check(32'(wb_adr), 32'(bus[66:37]), "wb_adr");
                check(32'(wb_stb), 32'd1, "wb_stb");
                check(32'(wb_we), 32'(bus[36]), "wb_we");
                check(32'(wb_sel), 32'(bus[35:32]), "wb_sel");
                // only enabled lanes carry store data
                if (bus[36]) begin
                    for (int b = 0; b < 4; b++) begin
                        mask[b*8 +: 8] = {8{bus[32+b]}};
                    end
                    check(wb_dat_w & mask, bus[31:0], "wb_dat_w");
                end
            end
        end
    end

    task automatic issue(input lsu_op_t op, input logic [31:0] base, input logic [11:0] off,
                         input logic [31:0] data);
        logic [31:0] ea;
        logic [31:0] word;
        logic [31:0] lanes;
        logic [31:0] val;
        logic [3:0]  sel;
        logic [7:0]  idx;
        logic [4:0]  rd;
        logic        store;
        int          lane;
        ea    = base + {{20{off[11]}}, off};
        idx   = ea[9:2];
        word  = ref_mem[idx];
        rd    = next_uuid[4:0] ^ 5'h15;
        store = op inside {SB, SH, SW};
        case (op)
            LB, LBU, SB: sel = 4'b0001 << ea[1:0];
            LH, LHU, SH: sel = 4'b0011 << ea[1:0];
            default:     sel = 4'b1111;
        endcase
        lanes = '0;
        if (store) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    // lane b takes the store byte b minus the alignment
                    lane = b - int'(ea[1:0]);
                    lanes[b*8 +: 8] = data[lane*8 +: 8];
                    word[b*8 +: 8] = lanes[b*8 +: 8];
                end
            end
            ref_mem[idx] = word;
            exp_st.push_back(next_uuid);
        end else begin
            val = word >> {ea[1:0], 3'b000};
            case (op)
                LB:      val = {{24{val[7]}}, val[7:0]};
                LBU:     val = {24'h0, val[7:0]};
                LH:      val = {{16{val[15]}}, val[15:0]};
                LHU:     val = {16'h0, val[15:0]};
                default: val = word;
            endcase
            exp_ld.push_back({next_uuid, rd, val});
        end
        exp_bus.push_back({ea[31:2], store, sel, lanes});
        req_valid      <= 1'b1;
        req_op         <= op;
        req_base       <= base;
        req_offset     <= off;
        req_store_data <= data;
        req_rd         <= rd;
        req_uuid       <= next_uuid;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
        next_uuid = next_uuid + 8'd1;
        issued++;
    endtask

    task automatic drain(input int n);
        logic [44:0] ld;
        logic [7:0]  st;
        int          got;
        got = 0;
        while (got < n) begin
            @(posedge clk);
            if (result_valid && result_ready) begin
                got++;
                if (result_wb && exp_ld.size() == 0) begin
                    $display("load result uuid %0d with no load outstanding", result_uuid);
                    errors++;
                end else if (!result_wb && exp_st.size() == 0) begin
                    $display("store completion uuid %0d with no store outstanding", result_uuid);
                    errors++;
                end else if (result_wb) begin
                    ld = exp_ld.pop_front();
                    check(32'(result_uuid), 32'(ld[44:37]), "load uuid");
                    check(32'(result_rd), 32'(ld[36:32]), "load rd");
                    check(result_data, ld[31:0], "load data");
                end else begin
                    st = exp_st.pop_front();
                    check(32'(result_uuid), 32'(st), "store uuid");
                    check(32'(result_rd), 32'd0, "store rd");
                    check(result_data, 32'd0, "store data");
                end
            end
        end
    endtask

    task automatic run_one(input lsu_op_t op, input logic [31:0] base, input logic [11:0] off,
                           input logic [31:0] data);
        issue(op, base, off, data);
        drain(1);
    endtask

    task automatic report_test(input string name);
        check(32'(exp_ld.size()), 32'd0, "loads still outstanding");
        check(32'(exp_st.size()), 32'd0, "stores still outstanding");
        check(32'(exp_bus.size()), 32'd0, "bus cycles still outstanding");
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    task automatic check_reset_state();
        check(32'(wb_cyc), 32'd0, "wb_cyc after reset");
        check(32'(wb_stb), 32'd0, "wb_stb after reset");
        check(32'(result_valid), 32'd0, "result_valid after reset");
        check(32'(req_ready), 32'd1, "req_ready after reset");
        report_test("reset state");
    endtask

    task automatic store_then_load();
        run_one(SW, 32'h40, 12'h000, 32'hcafe_f00d);
        run_one(LW, 32'h3c, 12'h004, 32'h0);
        report_test("store then load");
    endtask

    task automatic partial_stores();
        run_one(SW, 32'h80, 12'h000, 32'h1122_3344);
        for (int a = 0; a < 4; a++) begin
            run_one(SB, 32'h80, 12'(a), 32'hdead_bec0 + 32'(a));
            run_one(LW, 32'h80, 12'h000, 32'h0);
        end
        for (int a = 0; a < 4; a += 2) begin
            run_one(SH, 32'h80, 12'(a), 32'h7777_5a00 + 32'(a));
            run_one(LW, 32'h80, 12'h000, 32'h0);
        end
        report_test("partial stores");
    endtask

    task automatic load_extension();
        // every byte and half has its top bit set
        run_one(SW, 32'hc0, 12'h000, 32'h80ff_a5c3);
        for (int a = 0; a < 4; a++) begin
            run_one(LB, 32'hc0, 12'(a), 32'h0);
            run_one(LBU, 32'hc0, 12'(a), 32'h0);
        end
        for (int a = 0; a < 4; a += 2) begin
            run_one(LH, 32'hc0, 12'(a), 32'h0);
            run_one(LHU, 32'hc0, 12'(a), 32'h0);
        end
        report_test("load extension");
    endtask

    task automatic address_arithmetic();
        run_one(SW, 32'h0000_0200, 12'hf00, 32'h0102_0304);
        run_one(LW, 32'h0000_00f8, 12'h008, 32'h0);
        // carry and borrow across bit 11
        run_one(SW, 32'h0001_0ff8, 12'h7fc, 32'h5566_7788);
        run_one(LW, 32'h0001_1800, 12'hff4, 32'h0);
        run_one(SW, 32'h0002_0000, 12'h800, 32'h99aa_bbcc);
        run_one(LW, 32'h0001_f404, 12'h3fc, 32'h0);
        report_test("address arithmetic");
    endtask

    task automatic burst_backpressure();
        int start;
        start = issued;
        result_ready <= 1'b0;
        fork
            begin
                issue(SW, 32'h200, 12'h000, 32'h8765_4321);
                issue(LW, 32'h200, 12'h000, 32'h0);
                issue(SW, 32'h204, 12'h000, 32'hfeed_8001);
                issue(LBU, 32'h200, 12'h001, 32'h0);
                issue(SH, 32'h204, 12'h002, 32'h0000_c3a5);
                issue(LH, 32'h204, 12'h002, 32'h0);
            end
            begin
                while (issued < start + 5) begin
                    @(posedge clk);
                end
                repeat (8) @(posedge clk);
                check(32'(req_ready), 32'd0, "req_ready with buffers full");
                check(32'(wb_cyc), 32'd0, "wb_cyc with store buffer full");
                check(32'(result_valid), 32'd1, "result_valid while stalled");
                result_ready <= 1'b1;
                drain(6);
            end
        join
        report_test("burst with back-pressure");
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        req_valid      = 1'b0;
        req_op         = LW;
        req_base       = '0;
        req_offset     = '0;
        req_store_data = '0;
        req_rd         = '0;
        req_uuid       = '0;
        result_ready   = 1'b1;
        next_uuid      = 8'd1;
        issued         = 0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        test_base      = 0;
        cycles         = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_reset_state();
        store_then_load();
        partial_stores();
        load_extension();
        address_arithmetic();
        burst_backpressure();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/lsu_pkg.sv
hdl/lsu_request_format.sv
hdl/lsu_wb_master.sv
hdl/lsu_load_align.sv
hdl/lsu_elastic_buffer.sv
hdl/lsu_result_arb.sv
hdl/lsu_top.sv
verif/tb_wb_memory.sv
verif/tb_lsu.sv

/* Makefile */
# Verilator build for the load/store unit

VERILATOR ?= verilator
TOP       ?= tb_lsu
LINT_TOP  ?= lsu_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?=
LINTFLAGS ?= -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

sim: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
